//--- rtl/dcache_config.svh
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// Bus widths
`define DC_ADDR_W 32
`define DC_DATA_W 32

// Geometry: 2 ways x 8 sets x 32-byte lines
`define DC_WAYS 2
`define DC_SETS 8
`define DC_INDEX_W 3
`define DC_OFFSET_W 5
`define DC_WORDS 8
`define DC_TAG_W 24

// Memory burst len field for a full line (8 beats)
`define DC_BURST_LEN 7

// Uncached regions
`define DC_UNCACHED_LIMIT 32'h20
`define DC_IO_MASK 32'hc000_0000

`endif

//--- rtl/dcache_pkg.sv
`include "dcache_config.svh"

package dcache_pkg;

  typedef logic [`DC_TAG_W-1:0] tag_t;

  typedef logic way_t; // 2 ways, one bit

  // CPU address split as seen by the tag/data store
  typedef struct packed {
    tag_t                    tag;
    logic [`DC_INDEX_W-1:0]  index;
    logic [2:0]              word;     // Word within the line
    logic [1:0]              byte_off; // Byte within the word
  } addr_fields_t;

  // Raw for region checks and memory requests, fields for lookup
  typedef union packed {
    logic [`DC_ADDR_W-1:0] raw;
    addr_fields_t          fields;
  } addr_t;

  // One cache line, word 0 in the low bits
  typedef logic [`DC_WORDS-1:0][`DC_DATA_W-1:0] line_t;

endpackage

//--- rtl/dcache_ifs.sv
`timescale 1ns/1ns
`include "dcache_config.svh"

// Controller <-> tag/data store
interface store_if;
  dcache_pkg::addr_t             addr;      // Latched request address
  logic [`DC_DATA_W-1:0]         wdata;
  logic [`DC_DATA_W/8-1:0]       wstrb;
  logic                          word_we;   // Merge write on hit way
  logic                          fill_we;   // One refill beat
  logic [`DC_DATA_W-1:0]         fill_data;
  dcache_pkg::way_t              fill_way;
  logic                          fill_first; // First refill beat, installs tag

  logic                          hit;
  dcache_pkg::way_t              hit_way;
  dcache_pkg::line_t             hit_line;
  dcache_pkg::way_t              victim_way;
  logic                          victim_dirty;
  dcache_pkg::tag_t              victim_tag;
  dcache_pkg::line_t             victim_line;

  modport ctrl (
    output addr, wdata, wstrb, word_we, fill_we, fill_data, fill_way, fill_first,
    input  hit, hit_way, hit_line, victim_way, victim_dirty, victim_tag, victim_line
  );

  modport store (
    input  addr, wdata, wstrb, word_we, fill_we, fill_data, fill_way, fill_first,
    output hit, hit_way, hit_line, victim_way, victim_dirty, victim_tag, victim_line
  );
endinterface

// Controller -> write-data serializer
interface drain_if;
  logic                    start;       // 1-cycle pulse, only while !busy
  dcache_pkg::line_t       line;        // Victim line for write-back
  logic [`DC_DATA_W-1:0]   single_word; // Bypass write word
  logic [`DC_DATA_W/8-1:0] single_strb;
  logic                    burst;       // 1 = 8-beat line, 0 = single beat
  logic                    busy;
  logic                    done;        // Pulse on last beat accepted

  modport ctrl (output start, line, single_word, single_strb, burst, input busy, done);
  modport drain (input start, line, single_word, single_strb, burst, output busy, done);
endinterface

//--- rtl/dcache_store.sv
`timescale 1ns/1ns
`include "dcache_config.svh"

module dcache_store (
  input logic     clk,
  input logic     rst,
  store_if.store  s
);

  // Per-way state arrays
  logic [`DC_WAYS-1:0][`DC_SETS-1:0] valid_q;
  logic [`DC_WAYS-1:0][`DC_SETS-1:0] dirty_q;
  logic [`DC_SETS-1:0]               lru_q;   // Way to evict next
  dcache_pkg::tag_t                  tag_q  [`DC_WAYS][`DC_SETS];
  dcache_pkg::line_t                 data_q [`DC_WAYS][`DC_SETS];

  logic [`DC_INDEX_W-1:0] idx;
  logic [2:0]             word;
  logic [`DC_WAYS-1:0]    way_hit;
  dcache_pkg::way_t       hit_way;
  dcache_pkg::way_t       victim_way;

  assign idx  = s.addr.fields.index;
  assign word = s.addr.fields.word;

  // Tag compare, all ways in parallel
  always_comb begin
    way_hit = '0;
    for (int w = 0; w < `DC_WAYS; w++) begin
      way_hit[w] = valid_q[w][idx] && (tag_q[w][idx] == s.addr.fields.tag);
    end
  end

  assign hit_way = way_hit[1]; // Two ways, at most one matches

  // Fill empty ways first, then follow LRU
  always_comb begin
    if (!valid_q[0][idx]) begin
      victim_way = 1'b0;
    end else if (!valid_q[1][idx]) begin
      victim_way = 1'b1;
    end else begin
      victim_way = lru_q[idx];
    end
  end

  assign s.hit          = |way_hit;
  assign s.hit_way      = hit_way;
  assign s.hit_line     = data_q[hit_way][idx];
  assign s.victim_way   = victim_way;
  assign s.victim_dirty = dirty_q[victim_way][idx]; // Only ever set on a valid line
  assign s.victim_tag   = tag_q[victim_way][idx];
  assign s.victim_line  = data_q[victim_way][idx];

  // Valid, dirty and LRU bits
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      dirty_q <= '0;
      lru_q   <= '0;
    end else begin
      if (s.word_we && s.hit) begin
        dirty_q[hit_way][idx] <= 1'b1;
        lru_q[idx]            <= ~hit_way; // Other way becomes the victim
      end
      // New line is clean and most recently used
      if (s.fill_first) begin
        valid_q[s.fill_way][idx] <= 1'b1;
        dirty_q[s.fill_way][idx] <= 1'b0;
        lru_q[idx]               <= ~s.fill_way;
      end
    end
  end

  // Tags and line data
  always_ff @(posedge clk) begin
    if (s.fill_first) begin
      tag_q[s.fill_way][idx] <= s.addr.fields.tag;
    end
    if (s.fill_we) begin
      // Beats arrive in word order, shift in from the top
      data_q[s.fill_way][idx] <= {s.fill_data, data_q[s.fill_way][idx][`DC_WORDS-1:1]};
    end else if (s.word_we && s.hit) begin
      for (int b = 0; b < `DC_DATA_W/8; b++) begin
        if (s.wstrb[b]) begin
          data_q[hit_way][idx][word][8*b +: 8] <= s.wdata[8*b +: 8]; // Byte merge
        end
      end
    end
  end

endmodule

//--- rtl/dcache_drain.sv
`timescale 1ns/1ns
`include "dcache_config.svh"

module dcache_drain (
  input  logic                    clk,
  input  logic                    rst,
  drain_if.drain                  d,
  output logic                    wr_data_valid,
  output logic [`DC_DATA_W-1:0]   wr_data,
  output logic [`DC_DATA_W/8-1:0] wr_data_strb,
  output logic                    wr_data_last,
  input  logic                    wr_data_ready
);

  dcache_pkg::line_t       buf_q;  // Words left to send, next in word 0
  logic [2:0]              left_q; // Beats left after the current one
  logic [`DC_DATA_W/8-1:0] strb_q;
  logic                    busy_q;
  logic                    beat;

  assign beat = busy_q && wr_data_ready; // Beat accepted

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= 1'b0;
      left_q <= '0;
    end else if (d.start) begin
      busy_q <= 1'b1;
      left_q <= d.burst ? 3'(`DC_BURST_LEN) : 3'd0;
    end else if (beat) begin
      left_q <= left_q - 3'd1;
      if (left_q == 3'd0) begin
        busy_q <= 1'b0; // Last beat gone
      end
    end
  end

  always_ff @(posedge clk) begin
    if (d.start) begin
      buf_q  <= d.burst ? d.line
                        : {{(`DC_WORDS-1)*`DC_DATA_W{1'b0}}, d.single_word};
      strb_q <= d.burst ? '1 : d.single_strb; // Full words on write-back
    end else if (beat) begin
      buf_q <= {{`DC_DATA_W{1'b0}}, buf_q[`DC_WORDS-1:1]};
    end
  end

  assign wr_data_valid = busy_q;
  assign wr_data       = buf_q[0];
  assign wr_data_strb  = strb_q;
  assign wr_data_last  = busy_q && (left_q == 3'd0);

  assign d.busy = busy_q;
  assign d.done = beat && (left_q == 3'd0);

endmodule

//--- rtl/dcache_ctrl.sv
`timescale 1ns/1ns
`include "dcache_config.svh"

module dcache_ctrl (
  input  logic                    clk,
  input  logic                    rst,
  // CPU request
  input  logic                    req_valid,
  input  logic                    req_write,
  input  logic [`DC_ADDR_W-1:0]   req_addr,
  input  logic [`DC_DATA_W-1:0]   req_wdata,
  input  logic [`DC_DATA_W/8-1:0] req_wstrb,
  output logic                    req_ready,
  // CPU response
  output logic                    rsp_valid,
  output logic [`DC_DATA_W-1:0]   rsp_data,
  input  logic                    rsp_ready,
  // Memory read
  output logic                    rd_req_valid,
  output logic [`DC_ADDR_W-1:0]   rd_req_addr,
  output logic [7:0]              rd_req_len,
  input  logic                    rd_req_ready,
  input  logic                    rd_rsp_valid,
  input  logic [`DC_DATA_W-1:0]   rd_rsp_data,
  input  logic                    rd_rsp_last,
  output logic                    rd_rsp_ready,
  // Memory write request, data goes through the drain
  output logic                    wr_req_valid,
  output logic [`DC_ADDR_W-1:0]   wr_req_addr,
  output logic [7:0]              wr_req_len,
  input  logic                    wr_req_ready,
  store_if.ctrl                   st,
  drain_if.ctrl                   dr
);

  typedef enum logic [3:0] {
    IDLE, LOOKUP, RSP, WR_HIT,
    WB_REQ, WB_DATA, RF_REQ, RF_DATA,
    BP_RD_REQ, BP_RD_DATA, BP_WR_REQ, BP_WR_DATA
  } state_t;

  state_t state_q, state_d;

  // Latched request
  dcache_pkg::addr_t       addr_q;
  logic                    write_q;
  logic [`DC_DATA_W-1:0]   wdata_q;
  logic [`DC_DATA_W/8-1:0] wstrb_q;

  dcache_pkg::way_t        fill_way_q; // Victim chosen at miss time
  logic [2:0]              beat_q;     // Refill beat number
  logic                    bypass;
  logic                    wr_acc;
  logic                    rf_beat;
  logic                    rf_end;
  logic [`DC_ADDR_W-1:0]   line_addr;

  // Low page and I/O space are never cached
  assign bypass = (addr_q.raw < `DC_UNCACHED_LIMIT) || |(addr_q.raw & `DC_IO_MASK);
  assign line_addr = {addr_q.raw[`DC_ADDR_W-1:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}};

  assign wr_acc  = wr_req_valid && wr_req_ready;
  assign rf_beat = (state_q == RF_DATA) && rd_rsp_valid;
  assign rf_end  = rf_beat && (rd_rsp_last || beat_q == 3'd7);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin // Accept edge
      addr_q.raw <= req_addr;
      write_q    <= req_write;
      wdata_q    <= req_wdata;
      wstrb_q    <= req_wstrb;
    end
    if (state_q == LOOKUP && !st.hit) begin
      fill_way_q <= st.victim_way;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      beat_q <= '0;
    end else if (state_q == RF_REQ) begin
      beat_q <= '0;
    end else if (rf_beat) begin
      beat_q <= beat_q + 3'd1;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:       if (req_valid) state_d = LOOKUP;
      LOOKUP: begin
        if (bypass) begin
          state_d = write_q ? BP_WR_REQ : BP_RD_REQ;
        end else if (st.hit) begin
          state_d = write_q ? WR_HIT : RSP;
        end else begin
          state_d = st.victim_dirty ? WB_REQ : RF_REQ; // Write back before refill
        end
      end
      RSP:        if (rsp_ready) state_d = IDLE;
      WR_HIT:     state_d = IDLE;
      WB_REQ:     if (wr_acc) state_d = WB_DATA;
      WB_DATA:    if (dr.done) state_d = RF_REQ;
      RF_REQ:     if (rd_req_ready) state_d = RF_DATA;
      RF_DATA:    if (rf_end) state_d = LOOKUP; // Retry, now a hit
      BP_RD_REQ:  if (rd_req_ready) state_d = BP_RD_DATA;
      BP_RD_DATA: if (rd_rsp_valid && rsp_ready) state_d = IDLE;
      BP_WR_REQ:  if (wr_acc) state_d = BP_WR_DATA;
      BP_WR_DATA: if (dr.done) state_d = IDLE;
      default:    state_d = IDLE;
    endcase
  end

  // CPU side
  assign req_ready = (state_q == IDLE);
  assign rsp_valid = (state_q == RSP) || (state_q == BP_RD_DATA && rd_rsp_valid);
  assign rsp_data  = (state_q == BP_RD_DATA) ? rd_rsp_data
                                             : st.hit_line[addr_q.fields.word];

  // Memory read request, line aligned for refill
  assign rd_req_valid = (state_q == RF_REQ) || (state_q == BP_RD_REQ);
  assign rd_req_addr  = (state_q == BP_RD_REQ) ? addr_q.raw : line_addr;
  assign rd_req_len   = (state_q == BP_RD_REQ) ? 8'd0 : 8'(`DC_BURST_LEN);
  // Bypass beat passes straight through to the CPU
  assign rd_rsp_ready = (state_q == RF_DATA) || (state_q == BP_RD_DATA && rsp_ready);

  // Memory write request, held off while the drain is still sending
  assign wr_req_valid = ((state_q == WB_REQ) || (state_q == BP_WR_REQ)) && !dr.busy;
  assign wr_req_addr  = (state_q == WB_REQ)
                        ? {st.victim_tag, addr_q.fields.index, {`DC_OFFSET_W{1'b0}}}
                        : addr_q.raw;
  assign wr_req_len   = (state_q == WB_REQ) ? 8'(`DC_BURST_LEN) : 8'd0;

  // Drain starts as the write request is taken
  assign dr.start       = wr_acc;
  assign dr.burst       = (state_q == WB_REQ);
  assign dr.line        = st.victim_line;
  assign dr.single_word = wdata_q;
  assign dr.single_strb = wstrb_q;

  // Store side
  assign st.addr       = addr_q;
  assign st.wdata      = wdata_q;
  assign st.wstrb      = wstrb_q;
  assign st.word_we    = (state_q == WR_HIT);
  assign st.fill_we    = rf_beat;
  assign st.fill_data  = rd_rsp_data;
  assign st.fill_way   = fill_way_q;
  assign st.fill_first = rf_beat && (beat_q == 3'd0);

endmodule

//--- rtl/dcache_top.sv
`timescale 1ns/1ns
`include "dcache_config.svh"

module dcache_top (
  input  logic                    clk,
  input  logic                    rst,
  // CPU request
  input  logic                    req_valid,
  input  logic                    req_write,
  input  logic [`DC_ADDR_W-1:0]   req_addr,
  input  logic [`DC_DATA_W-1:0]   req_wdata,
  input  logic [`DC_DATA_W/8-1:0] req_wstrb,
  output logic                    req_ready,
  // CPU response
  output logic                    rsp_valid,
  output logic [`DC_DATA_W-1:0]   rsp_data,
  input  logic                    rsp_ready,
  // Memory read request
  output logic                    rd_req_valid,
  output logic [`DC_ADDR_W-1:0]   rd_req_addr,
  output logic [7:0]              rd_req_len,
  input  logic                    rd_req_ready,
  // Memory read response
  input  logic                    rd_rsp_valid,
  input  logic [`DC_DATA_W-1:0]   rd_rsp_data,
  input  logic                    rd_rsp_last,
  output logic                    rd_rsp_ready,
  // Memory write request
  output logic                    wr_req_valid,
  output logic [`DC_ADDR_W-1:0]   wr_req_addr,
  output logic [7:0]              wr_req_len,
  input  logic                    wr_req_ready,
  // Memory write data
  output logic                    wr_data_valid,
  output logic [`DC_DATA_W-1:0]   wr_data,
  output logic [`DC_DATA_W/8-1:0] wr_data_strb,
  output logic                    wr_data_last,
  input  logic                    wr_data_ready
);

  store_if st ();
  drain_if dr ();

  // FSM, request latch and memory request channels
  dcache_ctrl u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .req_valid    (req_valid),
    .req_write    (req_write),
    .req_addr     (req_addr),
    .req_wdata    (req_wdata),
    .req_wstrb    (req_wstrb),
    .req_ready    (req_ready),
    .rsp_valid    (rsp_valid),
    .rsp_data     (rsp_data),
    .rsp_ready    (rsp_ready),
    .rd_req_valid (rd_req_valid),
    .rd_req_addr  (rd_req_addr),
    .rd_req_len   (rd_req_len),
    .rd_req_ready (rd_req_ready),
    .rd_rsp_valid (rd_rsp_valid),
    .rd_rsp_data  (rd_rsp_data),
    .rd_rsp_last  (rd_rsp_last),
    .rd_rsp_ready (rd_rsp_ready),
    .wr_req_valid (wr_req_valid),
    .wr_req_addr  (wr_req_addr),
    .wr_req_len   (wr_req_len),
    .wr_req_ready (wr_req_ready),
    .st           (st.ctrl),
    .dr           (dr.ctrl)
  );

  dcache_store u_store (
    .clk (clk),
    .rst (rst),
    .s   (st.store)
  );

  // Write-back and bypass write beats
  dcache_drain u_drain (
    .clk           (clk),
    .rst           (rst),
    .d             (dr.drain),
    .wr_data_valid (wr_data_valid),
    .wr_data       (wr_data),
    .wr_data_strb  (wr_data_strb),
    .wr_data_last  (wr_data_last),
    .wr_data_ready (wr_data_ready)
  );

endmodule

//--- dv/dcache_tb.sv
`timescale 1ns/1ns

module dcache_tb;

  localparam int TIMEOUT = 300; // Cycles allowed for any single wait

  logic clk = 1'b0;
  logic rst;
  logic req_valid, req_write, req_ready;
  logic [31:0] req_addr, req_wdata;
  logic [3:0] req_wstrb;
  logic rsp_valid, rsp_ready;
  logic [31:0] rsp_data;
  logic rd_req_valid, rd_req_ready, rd_rsp_valid, rd_rsp_last, rd_rsp_ready;
  logic [31:0] rd_req_addr, rd_rsp_data;
  logic [7:0] rd_req_len;
  logic wr_req_valid, wr_req_ready;
  logic [31:0] wr_req_addr;
  logic [7:0] wr_req_len;
  logic wr_data_valid, wr_data_last, wr_data_ready;
  logic [31:0] wr_data;
  logic [3:0] wr_data_strb;

  // Memory model words keyed by aligned byte address
  logic [31:0] mem [logic [31:0]];
  int rd_req_count = 0;
  int wr_req_count = 0;
  logic [31:0] rd_last_addr, wr_last_addr;
  int rd_last_len, wr_last_len;
  logic [31:0] beat_data [$]; // Every write beat seen in order
  logic [3:0] beat_strb [$];
  logic beat_last [$];
  int rd_model_errs = 0;
  int wr_model_errs = 0;

  int errors = 0; // Main flow mismatches and timeouts
  int tests_run = 0;
  int tests_failed = 0;

  dcache_top dut (.*);

  initial begin
    forever #50 clk = ~clk; // 100 ns period
  end

  // Untouched memory holds address XOR pattern
  function automatic logic [31:0] init_word(input logic [31:0] addr);
    return {addr[31:2], 2'b00} ^ 32'h5a5a_0000;
  endfunction

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [31:0] key;
    key = {addr[31:2], 2'b00};
    return mem.exists(key) ? mem[key] : init_word(key);
  endfunction

  // Byte lanes with strobe set take the new data
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w, input logic [31:0] new_w,
                                              input logic [3:0] strb);
    logic [31:0] r;
    r = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) r[8*b +: 8] = new_w[8*b +: 8];
    end
    return r;
  endfunction

  function automatic int total_errors();
    return errors + rd_model_errs + wr_model_errs;
  endfunction

  task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
    errors++;
  endtask

  task automatic report_result(input string name, input int errs_before);
    tests_run++;
    if (total_errors() > errs_before) begin
      tests_failed++;
      $display("%s: FAIL, %0d failed checks", name, total_errors() - errs_before);
    end else begin
      $display("%s: pass", name);
    end
  endtask

  // Read side of the memory model with random stalls on request and beats
  initial begin : read_model
    logic [31:0] base;
    int len;
    int t;
    bit ok;
    rd_req_ready = 1'b0;
    rd_rsp_valid = 1'b0;
    rd_rsp_data  = '0;
    rd_rsp_last  = 1'b0;
    forever begin
      @(posedge clk);
      if (rd_req_valid === 1'b1) begin
        @(negedge clk);
        repeat ($urandom_range(0, 3)) @(negedge clk);
        rd_req_ready = 1'b1;
        @(posedge clk); // Valid is held, so the transfer is here
        base = {rd_req_addr[31:2], 2'b00};
        len  = int'(rd_req_len);
        rd_last_addr = rd_req_addr;
        rd_last_len  = len;
        rd_req_count++;
        ok = 1'b1;
        for (int i = 0; i <= len && ok; i++) begin
          @(negedge clk);
          rd_req_ready = 1'b0;
          rd_rsp_valid = 1'b0;
          repeat ($urandom_range(0, 2)) @(negedge clk); // Gap between beats
          rd_rsp_valid = 1'b1;
          rd_rsp_data  = mem_word(base + 32'(4 * i));
          rd_rsp_last  = (i == len);
          t = 0;
          do begin
            @(posedge clk);
            t++;
          end while (rd_rsp_ready !== 1'b1 && t < TIMEOUT);
          if (rd_rsp_ready !== 1'b1) begin
            $display("timeout at %0t: read beat %0d was never taken", $time, i);
            rd_model_errs++;
            ok = 1'b0;
          end
        end
        @(negedge clk);
        rd_req_ready = 1'b0;
        rd_rsp_valid = 1'b0;
        rd_rsp_last  = 1'b0;
      end
    end
  end

  // Write side logs every beat and merges it into memory
  initial begin : write_model
    logic [31:0] base;
    int len;
    int t;
    bit ok;
    wr_req_ready  = 1'b0;
    wr_data_ready = 1'b0;
    forever begin
      @(posedge clk);
      if (wr_req_valid === 1'b1) begin
        @(negedge clk);
        repeat ($urandom_range(0, 3)) @(negedge clk);
        wr_req_ready = 1'b1;
        @(posedge clk);
        base = {wr_req_addr[31:2], 2'b00};
        len  = int'(wr_req_len);
        wr_last_addr = wr_req_addr;
        wr_last_len  = len;
        wr_req_count++;
        ok = 1'b1;
        for (int i = 0; i <= len && ok; i++) begin
          @(negedge clk);
          wr_req_ready  = 1'b0;
          wr_data_ready = 1'b0;
          repeat ($urandom_range(0, 2)) @(negedge clk); // Data stall
          wr_data_ready = 1'b1;
          t = 0;
          do begin
            @(posedge clk);
            t++;
          end while (wr_data_valid !== 1'b1 && t < TIMEOUT);
          if (wr_data_valid !== 1'b1) begin
            $display("timeout at %0t: write beat %0d never arrived", $time, i);
            wr_model_errs++;
            ok = 1'b0;
          end else begin
            beat_data.push_back(wr_data);
            beat_strb.push_back(wr_data_strb);
            beat_last.push_back(wr_data_last);
            mem[base + 32'(4 * i)] = merge_bytes(mem_word(base + 32'(4 * i)), wr_data,
                                                 wr_data_strb);
          end
        end
        @(negedge clk);
        wr_req_ready  = 1'b0;
        wr_data_ready = 1'b0;
      end
    end
  end

  // Present a request and wait for its accept edge
  task automatic issue_req(input logic write, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [3:0] strb);
    int t;
    @(negedge clk);
    req_valid = 1'b1;
    req_write = write;
    req_addr  = addr;
    req_wdata = wdata;
    req_wstrb = strb;
    t = 0;
    do begin
      @(posedge clk);
      t++;
    end while (req_ready !== 1'b1 && t < TIMEOUT);
    if (req_ready !== 1'b1) begin
      $display("timeout at %0t: request to %h was never accepted", $time, addr);
      errors++;
    end
    @(negedge clk);
    req_valid = 1'b0;
  endtask

  // Cycles are counted from the accept edge
  task automatic wait_rsp(output logic [31:0] data, output int lat);
    lat = 0;
    do begin
      @(posedge clk);
      lat++;
    end while (rsp_valid !== 1'b1 && lat < TIMEOUT);
    data = rsp_data;
    if (rsp_valid !== 1'b1) begin
      $display("timeout at %0t: no read response", $time);
      errors++;
    end
  endtask

  task automatic wait_idle(output int lat);
    lat = 0;
    do begin
      @(posedge clk);
      lat++;
    end while (req_ready !== 1'b1 && lat < TIMEOUT);
    if (req_ready !== 1'b1) begin
      $display("timeout at %0t: cache never went back to idle", $time);
      errors++;
    end
  endtask

  task automatic read_word(input logic [31:0] addr, output logic [31:0] data, output int lat);
    issue_req(1'b0, addr, 32'h0, 4'h0);
    wait_rsp(data, lat);
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] strb, output int lat);
    issue_req(1'b1, addr, wdata, strb);
    wait_idle(lat);
  endtask

  task automatic read_miss_then_hit();
    int e0, rd0, wr0, lat;
    logic [31:0] data;
    e0  = total_errors();
    rd0 = rd_req_count;
    wr0 = wr_req_count;
    read_word(32'h0000_1044, data, lat); // Cold miss in set 2
    if (data !== init_word(32'h1044)) mismatch("rsp_data", data, init_word(32'h1044));
    if (rd_last_addr !== 32'h1040) mismatch("rd_req_addr", rd_last_addr, 32'h1040);
    if (rd_last_len != 7) mismatch("rd_req_len", rd_last_len, 7);
    read_word(32'h0000_1048, data, lat); // Same line
    if (data !== init_word(32'h1048)) mismatch("rsp_data", data, init_word(32'h1048));
    if (lat != 2) mismatch("rsp_valid latency", lat, 2);
    if (rd_req_count - rd0 != 1) mismatch("read request count", rd_req_count - rd0, 1);
    if (wr_req_count != wr0) mismatch("write request count", wr_req_count - wr0, 0);
    report_result("read_miss_then_hit", e0);
  endtask

  task automatic write_hit_merge();
    int e0, rd0, wr0, lat;
    logic [31:0] data, exp;
    e0  = total_errors();
    rd0 = rd_req_count;
    wr0 = wr_req_count;
    write_word(32'h0000_1048, 32'h1122_3344, 4'b0101, lat);
    if (lat != 3) mismatch("req_ready latency", lat, 3);
    read_word(32'h0000_1048, data, lat);
    exp = merge_bytes(init_word(32'h1048), 32'h1122_3344, 4'b0101);
    if (data !== exp) mismatch("rsp_data", data, exp);
    if (lat != 2) mismatch("rsp_valid latency", lat, 2);
    if (rd_req_count != rd0) mismatch("read request count", rd_req_count - rd0, 0);
    if (wr_req_count != wr0) mismatch("write request count", wr_req_count - wr0, 0);
    report_result("write_hit_merge", e0);
  endtask

  task automatic dirty_eviction();
    int e0, rd0, wr0, b0, lat;
    logic [31:0] data, exp, merged;
    e0  = total_errors();
    rd0 = rd_req_count;
    wr0 = wr_req_count;
    b0  = beat_data.size();
    merged = merge_bytes(init_word(32'h1048), 32'h1122_3344, 4'b0101);
    read_word(32'h0000_2040, data, lat); // Fills the empty way
    if (data !== init_word(32'h2040)) mismatch("rsp_data", data, init_word(32'h2040));
    if (wr_req_count != wr0) mismatch("write request count", wr_req_count - wr0, 0);
    read_word(32'h0000_3040, data, lat); // LRU way holds the dirty line
    if (data !== init_word(32'h3040)) mismatch("rsp_data", data, init_word(32'h3040));
    if (wr_req_count - wr0 != 1) mismatch("write request count", wr_req_count - wr0, 1);
    if (wr_last_addr !== 32'h1040) mismatch("wr_req_addr", wr_last_addr, 32'h1040);
    if (wr_last_len != 7) mismatch("wr_req_len", wr_last_len, 7);
    if (beat_data.size() - b0 != 8) mismatch("write beat count", beat_data.size() - b0, 8);
    for (int i = 0; i < 8 && b0 + i < beat_data.size(); i++) begin
      exp = (i == 2) ? merged : init_word(32'h1040 + 32'(4 * i));
      if (beat_data[b0 + i] !== exp) mismatch("wr_data", beat_data[b0 + i], exp);
      if (beat_strb[b0 + i] !== 4'hf) mismatch("wr_data_strb", 32'(beat_strb[b0 + i]), 32'hf);
      if (beat_last[b0 + i] !== (i == 7)) mismatch("wr_data_last", 32'(beat_last[b0 + i]),
                                                   32'(i == 7));
    end
    if (mem_word(32'h1048) !== merged) mismatch("memory word 1048", mem_word(32'h1048), merged);
    if (rd_req_count - rd0 != 2) mismatch("read request count", rd_req_count - rd0, 2);
    report_result("dirty_eviction", e0);
  endtask

  task automatic bypass_access();
    int e0, rd0, wr0, b0, lat;
    logic [31:0] data, exp;
    e0 = total_errors();
    // Both ways of set 0 filled, the set that the bypass addresses index
    read_word(32'h0000_1000, data, lat);
    if (data !== init_word(32'h1000)) mismatch("rsp_data", data, init_word(32'h1000));
    read_word(32'h0000_2000, data, lat);
    if (data !== init_word(32'h2000)) mismatch("rsp_data", data, init_word(32'h2000));
    b0 = beat_data.size();
    read_word(32'hc000_0010, data, lat); // I/O space
    if (data !== init_word(32'hc000_0010)) mismatch("rsp_data", data, init_word(32'hc000_0010));
    if (rd_last_addr !== 32'hc000_0010) mismatch("rd_req_addr", rd_last_addr, 32'hc000_0010);
    if (rd_last_len != 0) mismatch("rd_req_len", rd_last_len, 0);
    write_word(32'h0000_0008, 32'hdead_beef, 4'b0011, lat); // Low page
    if (wr_last_addr !== 32'h8) mismatch("wr_req_addr", wr_last_addr, 32'h8);
    if (wr_last_len != 0) mismatch("wr_req_len", wr_last_len, 0);
    if (beat_data.size() - b0 != 1) begin
      mismatch("write beat count", beat_data.size() - b0, 1);
    end else begin
      if (beat_data[b0] !== 32'hdead_beef) mismatch("wr_data", beat_data[b0], 32'hdead_beef);
      if (beat_strb[b0] !== 4'b0011) mismatch("wr_data_strb", 32'(beat_strb[b0]), 32'h3);
      if (beat_last[b0] !== 1'b1) mismatch("wr_data_last", 32'(beat_last[b0]), 32'h1);
    end
    exp = merge_bytes(init_word(32'h8), 32'hdead_beef, 4'b0011);
    if (mem_word(32'h8) !== exp) mismatch("memory word 8", mem_word(32'h8), exp);
    rd0 = rd_req_count;
    wr0 = wr_req_count;
    read_word(32'h0000_1004, data, lat); // Set 0 lines still hit
    if (data !== init_word(32'h1004)) mismatch("rsp_data", data, init_word(32'h1004));
    if (lat != 2) mismatch("rsp_valid latency", lat, 2);
    read_word(32'h0000_2008, data, lat);
    if (data !== init_word(32'h2008)) mismatch("rsp_data", data, init_word(32'h2008));
    if (lat != 2) mismatch("rsp_valid latency", lat, 2);
    if (rd_req_count != rd0) mismatch("read request count", rd_req_count - rd0, 0);
    if (wr_req_count != wr0) mismatch("write request count", wr_req_count - wr0, 0);
    report_result("bypass_access", e0);
  endtask

  task automatic rsp_backpressure();
    int e0, n, lat;
    logic [31:0] held;
    e0 = total_errors();
    n  = $urandom_range(1, 10);
    @(negedge clk);
    rsp_ready = 1'b0;
    issue_req(1'b0, 32'h0000_2044, 32'h0, 4'h0);
    wait_rsp(held, lat);
    if (lat != 2) mismatch("rsp_valid latency", lat, 2);
    for (int k = 0; k < n; k++) begin // Response must hold
      @(posedge clk);
      if (rsp_valid !== 1'b1) mismatch("rsp_valid", 32'(rsp_valid), 32'h1);
      if (rsp_data !== held) mismatch("rsp_data", rsp_data, held);
      if (req_ready !== 1'b0) mismatch("req_ready", 32'(req_ready), 32'h0);
    end
    @(negedge clk);
    rsp_ready = 1'b1;
    @(posedge clk); // Transfer edge
    if (rsp_valid !== 1'b1) mismatch("rsp_valid", 32'(rsp_valid), 32'h1);
    if (held !== init_word(32'h2044)) mismatch("rsp_data", held, init_word(32'h2044));
    wait_idle(lat);
    report_result("rsp_backpressure", e0);
  endtask

  initial begin
    void'($urandom(32'h61c7_5ea1));
    rst       = 1'b1;
    req_valid = 1'b0;
    req_write = 1'b0;
    req_addr  = '0;
    req_wdata = '0;
    req_wstrb = '0;
    rsp_ready = 1'b1; // CPU normally takes responses at once
    repeat (5) @(negedge clk);
    rst = 1'b0;
    read_miss_then_hit();
    write_hit_merge();
    dirty_eviction();
    bypass_access();
    rsp_backpressure();
    $display("%0d tests run, %0d failed, %0d failed checks", tests_run, tests_failed,
             total_errors());
    if (total_errors() == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- sources.f
+incdir+rtl
rtl/dcache_pkg.sv
rtl/dcache_ifs.sv
rtl/dcache_store.sv
rtl/dcache_drain.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
dv/dcache_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns -Mdir obj_dir \
  --top-module dcache_tb -f sources.f

out=$(./obj_dir/Vdcache_tb)
echo "$out"

if echo "$out" | grep -qx 'NO ERRORS'; then
  exit 0
fi
exit 1
